// File: Makefile
TOP := tb_m6502

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: cpu_alu.sv
// Combinational accumulator ALU for the group 01 instructions, with N, Z and C results
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
  input  wire cpu_pkg::alu_op_e alu_op,
  input  wire cpu_pkg::byte_t   alu_a,
  input  wire cpu_pkg::byte_t   alu_b,
  input  wire                   carry_in,
  output cpu_pkg::byte_t        alu_result,
  output cpu_pkg::flags_t       alu_flags
);
  import cpu_pkg::*;

  byte_t      addend;
  logic       carry_op;
  logic [8:0] sum;
  logic       carry_out;

  // Subtract as A + ~B + C, so C set means no borrow
  assign addend   = (alu_op == ALU_SBC || alu_op == ALU_CMP) ? ~alu_b : alu_b;
  // CMP always subtracts as if carry were set
  assign carry_op = (alu_op == ALU_CMP) ? 1'b1 : carry_in;
  assign sum      = {1'b0, alu_a} + {1'b0, addend} + {8'h00, carry_op};

  always_comb
  begin
    alu_result = sum[7:0];
    carry_out  = carry_in;
    case (alu_op)
      ALU_ORA: alu_result = alu_a | alu_b;
      ALU_AND: alu_result = alu_a & alu_b;
      ALU_EOR: alu_result = alu_a ^ alu_b;
      ALU_STA: alu_result = alu_a;
      ALU_LDA: alu_result = alu_b;
      ALU_ADC: carry_out = sum[8];
      ALU_CMP: carry_out = sum[8];
      ALU_SBC: carry_out = sum[8];
    endcase
  end

  always_comb
  begin
    alu_flags         = '0;
    alu_flags[FLAG_N] = alu_result[7];
    alu_flags[FLAG_Z] = (alu_result == 8'h00);
    alu_flags[FLAG_C] = carry_out;
  end

endmodule

`default_nettype wire

// File: cpu_core.sv
// 6502 subset core: fetch, decode, addressing and execute FSM with A, X, Y, PC and N/Z/C
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpu_core (
  input  wire                   raw_clk,
  input  wire                   button_reset,
  input  wire                   run,
  input  wire cpu_pkg::byte_t   mem_rdata,
  output cpu_pkg::addr_t        mem_address,
  output cpu_pkg::byte_t        mem_wdata,
  output logic                  mem_write,
  output cpu_pkg::alu_op_e      alu_op,
  output cpu_pkg::byte_t        alu_a,
  output cpu_pkg::byte_t        alu_b,
  output logic                  carry_in,
  input  wire cpu_pkg::byte_t   alu_result,
  input  wire cpu_pkg::flags_t  alu_flags,
  output cpu_pkg::byte_t        reg_a,
  output cpu_pkg::byte_t        reg_y,
  output cpu_pkg::addr_t        pc,
  output logic                  halted
);
  import cpu_pkg::*;

  core_state_e state;
  addr_mode_e  addr_mode;
  addr_mode_e  dec_mode;
  op_group_e   op_group;
  byte_t       opcode;
  byte_t       operand;
  byte_t       result;
  byte_t       reg_x;
  byte_t       xfer_value;
  byte_t       store_value;
  addr_t       ea;
  flags_t      flags;
  flags_t      result_flags;
  logic [2:0]  operation;
  logic [2:0]  mode_field;
  logic        dec_legal;
  logic        is_store;
  logic        is_jmp;
  logic        branch_taken;
  logic        operand_at_pc;

  // Opcode layout is aaa_bbb_cc
  assign op_group   = op_group_e'(opcode[1:0]);
  assign operation  = opcode[7:5];
  assign mode_field = opcode[4:2];

  assign is_store      = (operation == 3'b100) &&
                         (addr_mode == MODE_ZERO_PAGE || addr_mode == MODE_ABSOLUTE);
  assign is_jmp        = (op_group == GROUP_CTRL) && (operation == 3'b010);
  assign operand_at_pc = (addr_mode == MODE_IMMEDIATE) || (addr_mode == MODE_RELATIVE);

  assign alu_op   = (op_group == GROUP_ALU) ? alu_op_e'(operation) : ALU_LDA;
  assign alu_a    = reg_a;
  assign alu_b    = operand;
  assign carry_in = flags[FLAG_C];

  assign mem_address = (state == ST_STORE_ISSUE ||
                        (state == ST_FETCH_ARG_ISSUE && !operand_at_pc)) ? ea : pc;
  assign mem_wdata   = result;
  assign mem_write   = (state == ST_STORE_ISSUE);
  assign halted      = (state == ST_HALTED) || (state == ST_ERROR);

  always_comb
  begin
    case (mode_field)
      3'b001:  dec_mode = MODE_ZERO_PAGE;
      3'b011:  dec_mode = MODE_ABSOLUTE;
      3'b100:  dec_mode = MODE_RELATIVE;
      3'b000:  dec_mode = (opcode == 8'h00) ? MODE_IMPLIED : MODE_IMMEDIATE;
      3'b010:  dec_mode = (op_group == GROUP_ALU) ? MODE_IMMEDIATE : MODE_IMPLIED;
      default: dec_mode = MODE_IMPLIED;
    endcase
    dec_legal = 1'b0;
    case (op_group)
      GROUP_CTRL:
        case (mode_field)
          3'b000:  dec_legal = (operation == 3'b000) || (operation == 3'b101);
          3'b001:  dec_legal = (operation[2:1] == 2'b10);
          3'b011:  dec_legal = (operation[2:1] == 2'b10) || (operation == 3'b010);
          3'b100:  dec_legal = (operation[2:1] != 2'b01);
          3'b010:  dec_legal = operation[2];
          3'b110:  dec_legal = (operation == 3'b100);
          default: dec_legal = 1'b0;
        endcase
      GROUP_ALU:
        dec_legal = (mode_field == 3'b001) || (mode_field == 3'b011) ||
                    (mode_field == 3'b010 && operation != 3'b100);
      GROUP_X:
        case (mode_field)
          3'b000:         dec_legal = (operation == 3'b101);
          3'b001, 3'b011: dec_legal = (operation[2:1] == 2'b10);
          3'b010:         dec_legal = operation[2] && (operation != 3'b111);
          default:        dec_legal = 1'b0;
        endcase
      GROUP_ILLEGAL:
        dec_legal = 1'b0;
    endcase
  end

  // Implied transfers, increments and decrements
  always_comb
  begin
    case (opcode)
      8'h88:   xfer_value = reg_y - 8'd1;
      8'hc8:   xfer_value = reg_y + 8'd1;
      8'he8:   xfer_value = reg_x + 8'd1;
      8'hca:   xfer_value = reg_x - 8'd1;
      8'h8a:   xfer_value = reg_x;
      8'h98:   xfer_value = reg_y;
      default: xfer_value = reg_a;
    endcase
    case (op_group)
      GROUP_CTRL: store_value = reg_y;
      GROUP_X:    store_value = reg_x;
      default:    store_value = reg_a;
    endcase
    case (operation)
      3'b000:  branch_taken = !flags[FLAG_N];
      3'b001:  branch_taken = flags[FLAG_N];
      3'b100:  branch_taken = !flags[FLAG_C];
      3'b101:  branch_taken = flags[FLAG_C];
      3'b110:  branch_taken = !flags[FLAG_Z];
      default: branch_taken = flags[FLAG_Z];
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state     <= ST_FETCH_OP_ISSUE;
      addr_mode <= MODE_IMPLIED;
      reg_a     <= '0;
      reg_x     <= '0;
      reg_y     <= '0;
      flags     <= '0;
      pc        <= `RESET_PC;
    end
    else
    begin
      case (state)
        // Hold here until the loader releases the bus
        ST_FETCH_OP_ISSUE:
          if (run)
            state <= ST_FETCH_OP_CAPTURE;
        ST_FETCH_OP_CAPTURE:
        begin
          opcode <= mem_rdata;
          pc     <= pc + 16'd1;
          state  <= ST_DECODE;
        end
        ST_DECODE:
        begin
          addr_mode <= dec_mode;
          if (!dec_legal)
            state <= ST_ERROR;
          else if (opcode == 8'h00)
            state <= ST_HALTED;
          else if (dec_mode == MODE_IMPLIED)
            state <= ST_EXECUTE;
          else if (dec_mode == MODE_IMMEDIATE || dec_mode == MODE_RELATIVE)
            state <= ST_FETCH_ARG_ISSUE;
          else
            state <= ST_FETCH_LO_ISSUE;
        end
        ST_FETCH_LO_ISSUE:
          state <= ST_FETCH_LO_CAPTURE;
        ST_FETCH_LO_CAPTURE:
        begin
          ea <= {8'h00, mem_rdata};
          pc <= pc + 16'd1;
          if (addr_mode == MODE_ABSOLUTE)
            state <= ST_FETCH_HI_ISSUE;
          else if (is_store)
            state <= ST_EXECUTE;
          else
            state <= ST_FETCH_ARG_ISSUE;
        end
        ST_FETCH_HI_ISSUE:
          state <= ST_FETCH_HI_CAPTURE;
        ST_FETCH_HI_CAPTURE:
        begin
          ea[15:8] <= mem_rdata;
          pc       <= pc + 16'd1;
          state    <= (is_store || is_jmp) ? ST_EXECUTE : ST_FETCH_ARG_ISSUE;
        end
        ST_FETCH_ARG_ISSUE:
          state <= ST_FETCH_ARG_CAPTURE;
        ST_FETCH_ARG_CAPTURE:
        begin
          operand <= mem_rdata;
          if (operand_at_pc)
            pc <= pc + 16'd1;
          state <= ST_EXECUTE;
        end
        ST_EXECUTE:
        begin
          result       <= is_store ? store_value : alu_result;
          result_flags <= alu_flags;
          state        <= ST_FETCH_OP_ISSUE;
          if (is_store)
            state <= ST_STORE_ISSUE;
          else if (addr_mode == MODE_IMPLIED)
          begin
            flags[FLAG_N] <= xfer_value[7];
            flags[FLAG_Z] <= (xfer_value == 8'h00);
            case (opcode)
              8'h88, 8'ha8, 8'hc8: reg_y <= xfer_value;
              8'haa, 8'hca, 8'he8: reg_x <= xfer_value;
              default:             reg_a <= xfer_value;
            endcase
          end
          else if (addr_mode == MODE_RELATIVE)
          begin
            // Offset is relative to the next instruction
            if (branch_taken)
              pc <= pc + {{8{operand[7]}}, operand};
          end
          else if (is_jmp)
            pc <= ea;
          else
            state <= ST_WRITEBACK;
        end
        ST_WRITEBACK:
        begin
          flags <= result_flags;
          case (op_group)
            GROUP_CTRL: reg_y <= result;
            GROUP_X:    reg_x <= result;
            default:
              if (alu_op != ALU_CMP)
                reg_a <= result;
          endcase
          state <= ST_FETCH_OP_ISSUE;
        end
        ST_STORE_ISSUE:
          state <= ST_STORE_FINISH;
        ST_STORE_FINISH:
          state <= ST_FETCH_OP_ISSUE;
        ST_HALTED:
          state <= ST_HALTED;
        default:
          state <= ST_ERROR;
      endcase
    end
  end

  // RAM belongs to the loader until run
  a_no_write_before_run: assert property (
    @(posedge raw_clk) disable iff (!button_reset) !run |-> !mem_write);

  // Only a reset brings a stopped core back
  a_halt_sticky: assert property (
    @(posedge raw_clk) (halted && button_reset) |=> halted);

endmodule

`default_nettype wire

// File: cpu_pkg.sv
// Shared data types and enums of the 6502 subset core, imported by the RTL and the testbench
`default_nettype none
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [7:0]                byte_t;
  typedef logic [15:0]               addr_t;
  typedef logic [`RAM_ADDR_BITS-1:0] ram_index_t;

  // Packed as {N, Z, C}
  typedef logic [2:0] flags_t;

  localparam int FLAG_N = 2;
  localparam int FLAG_Z = 1;
  localparam int FLAG_C = 0;

  // Low two bits of the opcode
  typedef enum logic [1:0] {
    GROUP_CTRL    = 2'b00,
    GROUP_ALU     = 2'b01,
    GROUP_X       = 2'b10,
    GROUP_ILLEGAL = 2'b11
  } op_group_e;

  // Top three opcode bits of group 01
  typedef enum logic [2:0] {
    ALU_ORA, ALU_AND, ALU_EOR, ALU_ADC, ALU_STA, ALU_LDA, ALU_CMP, ALU_SBC
  } alu_op_e;

  // Addressing mode after decode
  typedef enum logic [2:0] {
    MODE_IMPLIED, MODE_IMMEDIATE, MODE_ZERO_PAGE, MODE_ABSOLUTE, MODE_RELATIVE
  } addr_mode_e;

  typedef enum logic [3:0] {
    ST_FETCH_OP_ISSUE, ST_FETCH_OP_CAPTURE, ST_DECODE,
    ST_FETCH_LO_ISSUE, ST_FETCH_LO_CAPTURE,
    ST_FETCH_HI_ISSUE, ST_FETCH_HI_CAPTURE,
    ST_FETCH_ARG_ISSUE, ST_FETCH_ARG_CAPTURE,
    ST_EXECUTE, ST_WRITEBACK, ST_STORE_ISSUE, ST_STORE_FINISH,
    ST_HALTED, ST_ERROR
  } core_state_e;

endpackage

`default_nettype wire

// File: cpu_settings.svh
// Build-time constants for the 6502 subset system, included by the package, RTL and testbench
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// RAM holds 2**RAM_ADDR_BITS bytes and mirrors through the 16-bit space
`define RAM_ADDR_BITS 10

// First loaded byte and first fetch after the load
`define RESET_PC 16'h0200

// Display scan counter width
// 6 keeps simulation short, 10 suits the board clock
`define SCAN_BITS 6

// Active-low column codes of the 8x4 LED matrix
`define COL_A     4'b0111
`define COL_Y     4'b1011
`define COL_PC_LO 4'b1101
`define COL_PC_HI 4'b1110

`endif

// File: led_scanner.sv
// LED matrix driver that cycles A, Y, PC low and PC high onto the active-low 8x4 display
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module led_scanner (
  input  wire                 raw_clk,
  input  wire                 button_reset,
  input  wire cpu_pkg::byte_t reg_a,
  input  wire cpu_pkg::byte_t reg_y,
  input  wire cpu_pkg::addr_t pc,
  output cpu_pkg::byte_t      leds,
  output logic [3:0]          column
);
  import cpu_pkg::*;

  logic [`SCAN_BITS-1:0] scan_count;
  logic [2:0]            slot;
  logic [3:0]            column_code;
  byte_t                 shown;

  // Top two bits pick the column, odd slots blank the matrix in between
  assign slot = scan_count[`SCAN_BITS-1 -: 3];

  always_comb
  begin
    case (slot[2:1])
      2'b00:   {column_code, shown} = {`COL_A, reg_a};
      2'b01:   {column_code, shown} = {`COL_Y, reg_y};
      2'b10:   {column_code, shown} = {`COL_PC_LO, pc[7:0]};
      default: {column_code, shown} = {`COL_PC_HI, pc[15:8]};
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      scan_count <= '0;
      column     <= 4'b1111;
      leds       <= 8'hff;
    end
    else
    begin
      scan_count <= scan_count + 1'b1;
      column     <= slot[0] ? 4'b1111 : column_code;
      leds       <= slot[0] ? 8'hff : ~shown;
    end
  end

  // At most one column is pulled low at a time
  a_one_column: assert property (
    @(posedge raw_clk) disable iff (!button_reset) $onehot0(~column));

endmodule

`default_nettype wire

// File: m6502_top.sv
// Top level of the 6502 subset system: loader, RAM, core, ALU and LED scanner
`timescale 1ns/1ps
`default_nettype none

module m6502_top (
  input  wire                 raw_clk,
  input  wire                 button_reset,
  input  wire                 load_strobe,
  input  wire cpu_pkg::byte_t load_data,
  input  wire                 load_last,
  output cpu_pkg::byte_t      leds,
  output logic [3:0]          column,
  output logic                halted
);
  import cpu_pkg::*;

  // Core side of the memory bus
  addr_t      core_address;
  byte_t      core_wdata;
  logic       core_write;
  byte_t      mem_rdata;
  logic       run;

  // RAM side after the loader mux
  ram_index_t ram_index;
  byte_t      ram_wdata;
  logic       ram_write;

  alu_op_e    alu_op;
  byte_t      alu_a;
  byte_t      alu_b;
  logic       carry_in;
  byte_t      alu_result;
  flags_t     alu_flags;

  // Registers shown on the display
  byte_t      reg_a;
  byte_t      reg_y;
  addr_t      pc;

  program_loader u_loader (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .load_strobe  (load_strobe),
    .load_data    (load_data),
    .load_last    (load_last),
    .core_address (core_address),
    .core_wdata   (core_wdata),
    .core_write   (core_write),
    .ram_index    (ram_index),
    .ram_wdata    (ram_wdata),
    .ram_write    (ram_write),
    .run          (run)
  );

  program_ram u_ram (
    .raw_clk   (raw_clk),
    .ram_index (ram_index),
    .ram_wdata (ram_wdata),
    .ram_write (ram_write),
    .mem_rdata (mem_rdata)
  );

  cpu_core u_core (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .mem_rdata    (mem_rdata),
    .mem_address  (core_address),
    .mem_wdata    (core_wdata),
    .mem_write    (core_write),
    .alu_op       (alu_op),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .carry_in     (carry_in),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .reg_a        (reg_a),
    .reg_y        (reg_y),
    .pc           (pc),
    .halted       (halted)
  );

  cpu_alu u_alu (
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .carry_in   (carry_in),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  led_scanner u_scanner (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .reg_a        (reg_a),
    .reg_y        (reg_y),
    .pc           (pc),
    .leds         (leds),
    .column       (column)
  );

endmodule

`default_nettype wire

// File: program_loader.sv
// Byte loader that fills RAM from RESET_PC with strobed bytes, then hands the bus to the core
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module program_loader (
  input  wire                 raw_clk,
  input  wire                 button_reset,
  input  wire                 load_strobe,
  input  wire cpu_pkg::byte_t load_data,
  input  wire                 load_last,
  input  wire cpu_pkg::addr_t core_address,
  input  wire cpu_pkg::byte_t core_wdata,
  input  wire                 core_write,
  output cpu_pkg::ram_index_t ram_index,
  output cpu_pkg::byte_t      ram_wdata,
  output logic                ram_write,
  output logic                run
);
  import cpu_pkg::*;

  ram_index_t write_ptr;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      write_ptr <= ram_index_t'(`RESET_PC);
      run       <= 1'b0;
    end
    else if (load_strobe && !run)
    begin
      write_ptr <= write_ptr + 1'b1;
      // Core starts on the cycle after the final byte
      if (load_last)
        run <= 1'b1;
    end
  end

  // Loader owns the port until run, then the core bus passes straight through
  assign ram_index = run ? core_address[`RAM_ADDR_BITS-1:0] : write_ptr;
  assign ram_wdata = run ? core_wdata : load_data;
  assign ram_write = run ? core_write : load_strobe;

  // Program bytes must all arrive before the core is released
  a_no_load_while_running: assert property (
    @(posedge raw_clk) disable iff (!button_reset) run |-> !load_strobe);

endmodule

`default_nettype wire

// File: program_ram.sv
// Single-port program and data RAM with a registered one-cycle read
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module program_ram (
  input  wire                     raw_clk,
  input  wire cpu_pkg::ram_index_t ram_index,
  input  wire cpu_pkg::byte_t     ram_wdata,
  input  wire                     ram_write,
  output cpu_pkg::byte_t          mem_rdata
);
  import cpu_pkg::*;

  localparam int DEPTH = 2 ** `RAM_ADDR_BITS;

  byte_t mem [0:DEPTH-1];

  // Data for an address issued in one cycle shows up in the next
  always_ff @(posedge raw_clk)
  begin
    if (ram_write)
      mem[ram_index] <= ram_wdata;
    mem_rdata <= mem[ram_index];
  end

endmodule

`default_nettype wire

// File: tb_clock.sv
// Testbench clock and power-on reset source for the 6502 subset system testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic raw_clk,
  output logic por_n
);

  initial
  begin
    raw_clk = 1'b0;
    forever #(PERIOD_NS / 2) raw_clk = ~raw_clk;
  end

  // Power-on reset released on a falling edge
  initial
  begin
    por_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge raw_clk);
    por_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_m6502.sv
// Testbench for the 6502 subset system; loads table programs, waits for halt, checks the display
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module tb_m6502;
  import cpu_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 2;
  localparam int MAX_BYTES       = 24;
  localparam int CYCLES_PER_BYTE = 24;
  localparam int MAX_GAP         = 2;
  localparam int SCAN_PERIOD     = 2 ** `SCAN_BITS;
  localparam int unsigned SEED   = 32'h522d_17c9;

  // Program bytes right-aligned, first byte highest
  typedef logic [MAX_BYTES*8-1:0] prog_t;

  logic       raw_clk;
  logic       por_n;
  logic       row_reset_n;
  logic       button_reset;
  logic       load_strobe;
  byte_t      load_data;
  logic       load_last;
  byte_t      leds;
  logic [3:0] column;
  logic       halted;

  prog_t row_code [$];
  int    row_len [$];
  byte_t row_a [$];
  byte_t row_y [$];
  addr_t row_pc [$];
  int    max_len;
  logic  table_ready;
  int    errors;
  int    checks;
  string phase;

  assign button_reset = por_n & row_reset_n;

  tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .raw_clk (raw_clk),
    .por_n   (por_n)
  );

  m6502_top u_dut (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .load_strobe  (load_strobe),
    .load_data    (load_data),
    .load_last    (load_last),
    .leds         (leds),
    .column       (column),
    .halted       (halted)
  );

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s %s: got %h, expected %h", phase, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s %s: got %h, expected %h", phase, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s %s: got %h, expected %h", phase, name, got, exp);
    end
  endtask

  task automatic check_column(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s %s: got %h, expected %h", phase, name, got, exp);
    end
  endtask

  task automatic add_row(input prog_t code, input int len, input byte_t a, input byte_t y,
                         input addr_t pc);
    row_code.push_back(code);
    row_len.push_back(len);
    row_a.push_back(a);
    row_y.push_back(y);
    row_pc.push_back(pc);
    if (len > max_len)
      max_len = len;
  endtask

  // Program, length, then A, Y and PC at halt
  task automatic build_table();
    max_len = 0;
    add_row(prog_t'(8'h00), 1, 8'h00, 8'h00, 16'h0201);
    add_row(prog_t'(40'ha9_5a_a0_c3_00), 5, 8'h5a, 8'hc3, 16'h0205);
    add_row(prog_t'(72'ha9_10_aa_e8_e8_8a_a8_88_00), 9, 8'h12, 8'h11, 16'h0209);
    add_row(prog_t'(72'ha0_ff_c8_98_aa_ca_ca_8a_00), 9, 8'hfe, 8'h00, 16'h0209);
    // ADC and SBC with carry in and out
    add_row(prog_t'(64'ha9_f0_69_20_69_01_a8_00), 8, 8'h12, 8'h12, 16'h0208);
    add_row(prog_t'(80'ha9_50_e9_10_e9_40_a8_69_01_00), 10, 8'h00, 8'hff, 16'h020a);
    add_row(prog_t'(80'ha9_f0_29_3c_09_05_a8_49_ff_00), 10, 8'hca, 8'h35, 16'h020a);
    add_row(prog_t'(96'ha9_40_c9_30_69_00_a8_c9_41_69_00_00), 12, 8'h42, 8'h41, 16'h020c);
    // Stores read back through loads and EOR
    add_row(prog_t'(184'ha9_a5_85_10_a2_3c_8e_45_03_a0_96_8c_46_03_ad_45_03_4d_46_03_a4_10_00),
            23, 8'haa, 8'ha5, 16'h0217);
    add_row(prog_t'(168'ha9_77_8d_50_03_a2_e1_86_12_a0_5c_84_13_a5_13_45_12_ac_50_03_00),
            21, 8'hbd, 8'h77, 16'h0215);
    // Y of 22 means taken, 11 means fall through
    add_row(prog_t'(72'ha0_22_a9_00_f0_02_a0_11_00), 9, 8'h00, 8'h22, 16'h0209);
    add_row(prog_t'(72'ha0_22_a9_01_f0_02_a0_11_00), 9, 8'h01, 8'h11, 16'h0209);
    add_row(prog_t'(72'ha0_22_a9_00_d0_02_a0_11_00), 9, 8'h00, 8'h11, 16'h0209);
    add_row(prog_t'(72'ha0_22_a9_01_d0_02_a0_11_00), 9, 8'h01, 8'h22, 16'h0209);
    add_row(prog_t'(88'ha0_22_a9_80_c9_10_b0_02_a0_11_00), 11, 8'h80, 8'h22, 16'h020b);
    add_row(prog_t'(88'ha0_22_a9_10_c9_20_b0_02_a0_11_00), 11, 8'h10, 8'h11, 16'h020b);
    add_row(prog_t'(88'ha0_22_a9_80_c9_10_90_02_a0_11_00), 11, 8'h80, 8'h11, 16'h020b);
    add_row(prog_t'(88'ha0_22_a9_10_c9_20_90_02_a0_11_00), 11, 8'h10, 8'h22, 16'h020b);
    add_row(prog_t'(72'ha0_22_a9_80_30_02_a0_11_00), 9, 8'h80, 8'h22, 16'h0209);
    add_row(prog_t'(72'ha0_22_a9_01_30_02_a0_11_00), 9, 8'h01, 8'h11, 16'h0209);
    add_row(prog_t'(72'ha0_22_a9_80_10_02_a0_11_00), 9, 8'h80, 8'h11, 16'h0209);
    add_row(prog_t'(72'ha0_22_a9_01_10_02_a0_11_00), 9, 8'h01, 8'h22, 16'h0209);
    add_row(prog_t'(64'ha0_22_4c_07_02_a0_11_00), 8, 8'h00, 8'h22, 16'h0208);
    // Group 11 opcode at 0202
    add_row(prog_t'(32'ha9_33_03_00), 4, 8'h33, 8'h00, 16'h0203);
  endtask

  task automatic apply_reset();
    @(negedge raw_clk);
    row_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge raw_clk);
    row_reset_n = 1'b1;
  endtask

  // One byte per strobe, with random idle cycles in between
  task automatic load_program(input int r);
    prog_t code;
    int    len;
    int    gap;
    code = row_code[r];
    len  = row_len[r];
    for (int i = 0; i < len; i++)
    begin
      @(negedge raw_clk);
      load_strobe = 1'b1;
      load_data   = code[8*(len-1-i) +: 8];
      load_last   = (i == len - 1);
      if (i < len - 1)
      begin
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap)
        begin
          @(negedge raw_clk);
          load_strobe = 1'b0;
          load_data   = 8'h00;
        end
      end
    end
    @(negedge raw_clk);
    load_strobe = 1'b0;
    load_data   = 8'h00;
    load_last   = 1'b0;
  endtask

  task automatic wait_halted(input int limit);
    int waited;
    waited = 0;
    while (halted !== 1'b1 && waited < limit)
    begin
      @(negedge raw_clk);
      waited++;
    end
    if (halted !== 1'b1)
      $display("%s: core did not halt within %0d cycles", phase, limit);
  endtask

  task automatic read_column(input logic [3:0] code, output byte_t value);
    int waited;
    waited = 0;
    value  = 8'h00;
    while (column !== code && waited < 2 * SCAN_PERIOD)
    begin
      @(negedge raw_clk);
      waited++;
    end
    if (column !== code)
    begin
      errors++;
      $display("%s: column code %b never appeared on the display", phase, code);
    end
    else
      value = ~leds;
  endtask

  task automatic check_display(input byte_t exp_a, input byte_t exp_y, input addr_t exp_pc);
    byte_t shown_a;
    byte_t shown_y;
    byte_t pc_lo;
    byte_t pc_hi;
    read_column(`COL_A, shown_a);
    read_column(`COL_Y, shown_y);
    read_column(`COL_PC_LO, pc_lo);
    read_column(`COL_PC_HI, pc_hi);
    check_byte("leds (A)", shown_a, exp_a);
    check_byte("leds (Y)", shown_y, exp_y);
    check_addr("leds (PC)", {pc_hi, pc_lo}, exp_pc);
  endtask

  initial
  begin
    row_reset_n = 1'b1;
    load_strobe = 1'b0;
    load_data   = 8'h00;
    load_last   = 1'b0;
    table_ready = 1'b0;
    errors      = 0;
    checks      = 0;
    phase       = "reset";
    void'($urandom(SEED));
    build_table();
    table_ready = 1'b1;

    // Outputs held by power-on reset
    @(negedge raw_clk);
    check_flag("halted", halted, 1'b0);
    check_column("column", column, 4'b1111);
    check_byte("leds", leds, 8'hff);

    wait (por_n);
    @(negedge raw_clk);
    phase = "after reset";
    check_flag("halted", halted, 1'b0);
    check_display(8'h00, 8'h00, `RESET_PC);

    for (int r = 0; r < row_code.size(); r++)
    begin
      phase = $sformatf("row %0d", r);
      apply_reset();
      load_program(r);
      wait_halted(max_len * CYCLES_PER_BYTE);
      check_flag("halted", halted, 1'b1);
      if (halted === 1'b1)
      begin
        // Let the scanner pick up the final register values
        repeat (2) @(negedge raw_clk);
        check_display(row_a[r], row_y[r], row_pc[r]);
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Budget per row covers reset, loading with gaps, execution and four column reads
  initial
  begin
    int budget;
    wait (table_ready);
    budget = (row_code.size() + 1) *
             (RESET_CYCLES + max_len * (MAX_GAP + 1 + CYCLES_PER_BYTE) + 8 * SCAN_PERIOD + 64);
    #(budget * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", budget);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
cpu_pkg.sv
program_loader.sv
program_ram.sv
cpu_alu.sv
cpu_core.sv
led_scanner.sv
m6502_top.sv
tb_clock.sv
tb_m6502.sv
